/* flist.f */
source/mrd_pkg.sv
source/mrd_bank_if.sv
source/mrd_operand_if.sv
source/mrd_ctrl_fsm.sv
source/mrd_cta_addr.sv
source/mrd_bank_map.sv
source/mrd_bank_mem.sv
source/mrd_read_seq.sv
source/mrd_top.sv
test/mrd_properties.sv
test/mrd_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mrd_tb -f flist.f -o mrd_sim \
	|| exit 1
result=$(./obj_dir/mrd_sim)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "TEST PASS" && exit 0 || exit 1

/* source/mrd_bank_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mrd_bank_if import mrd_pkg::*; ();

	// one read port per bank
	logic [NUM_BANKS-1:0] rden;
	row_t [NUM_BANKS-1:0] rdrow;

	// valid one cycle after rden
	sample_t [NUM_BANKS-1:0] rdata;

	// address side, owned by the read sequencer
	modport request
	(
		output rden,
		output rdrow,
		input  rdata
	);

	// storage side
	modport memory
	(
		input  rden,
		input  rdrow,
		output rdata
	);

endinterface

`default_nettype wire

/* source/mrd_bank_map.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_map import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic valid,
	input  addr_t [MAX_OPS-1:0] addrs,
	input  factor_t factor,
	mrd_bank_if.request bank,
	output bank_t [MAX_OPS-1:0] bank_index
);

	bank_t [MAX_OPS-1:0] slot_bank;
	row_t [MAX_OPS-1:0] slot_row;
	bank_t [MAX_OPS-1:0] idx_d1;
	logic [NUM_BANKS-1:0] rden_nxt;
	row_t [NUM_BANKS-1:0] rdrow_nxt;

	// address mod 7 picks the bank, div 7 the row
	always_comb
	begin
		for (int k = 0; k < MAX_OPS; k++)
		begin
			slot_row[k] = row_t'(addrs[k] / NUM_BANKS);
			if (factor_t'(k) < factor)
				slot_bank[k] = bank_t'(addrs[k] % NUM_BANKS);
			else
				slot_bank[k] = BANK_INVALID;
		end
	end

	// each bank takes the row of the slot that selects it
	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			rden_nxt[b] = 1'b0;
			rdrow_nxt[b] = '0;
			for (int k = 0; k < MAX_OPS; k++)
			begin
				if (slot_bank[k] == bank_t'(b))
				begin
					rden_nxt[b] = valid;
					rdrow_nxt[b] = slot_row[k];
				end
			end
		end
	end

	// bank_index lags two cycles to meet rdata
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bank.rden <= '0;
			idx_d1 <= {MAX_OPS{BANK_INVALID}};
			bank_index <= {MAX_OPS{BANK_INVALID}};
		end
		else
		begin
			bank.rden <= rden_nxt;
			idx_d1 <= slot_bank;
			bank_index <= idx_d1;
		end
	end

	always_ff @(posedge clk)
	begin
		bank.rdrow <= rdrow_nxt;
	end

endmodule

`default_nettype wire

/* source/mrd_bank_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_mem import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  fsm_state_t state,
	input  logic in_valid,
	input  sample_t in_data,
	mrd_bank_if.memory bank
);

	sample_t mem [NUM_BANKS][BANK_ROWS];
	bank_t wr_bank;
	row_t wr_row;
	logic wr_en;

	assign wr_en = (state == SINK) && in_valid;

	// write address kept as bank and row, i.e. a mod 7 and a div 7
	always_ff @(posedge clk)
	begin
		if (!rst_n || state != SINK)
		begin
			wr_bank <= '0;
			wr_row <= '0;
		end
		else if (in_valid)
		begin
			if (wr_bank == bank_t'(NUM_BANKS - 1))
			begin
				wr_bank <= '0;
				wr_row <= wr_row + row_t'(1);
			end
			else
				wr_bank <= wr_bank + bank_t'(1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_bank][wr_row] <= in_data;
	end

	// registered read per bank
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (bank.rden[b])
				bank.rdata[b] <= mem[b][bank.rdrow[b]];
		end
	end

endmodule

`default_nettype wire

/* source/mrd_cta_addr.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_cta_addr import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic issue,
	input  addr_t group,
	input  addr_t stride,
	input  factor_t factor,
	output addr_t [MAX_OPS-1:0] addrs,
	output twdl_t [MAX_OPS-1:0] twdl_numrtr,
	output logic valid
);

	addr_t grp_q;
	addr_t stride_q;
	factor_t fac_q;
	addr_t quot;
	addr_t rem;
	addr_t base;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid <= 1'b0;
		else
			valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		grp_q <= group;
		stride_q <= stride;
		fac_q <= factor;
	end

	// --------------------
	// operand k of group g sits at
	// (g / s) * s * f + (g % s) + k * s
	always_comb
	begin
		quot = grp_q / stride_q;
		rem = grp_q - quot * stride_q;
		base = quot * stride_q * addr_t'(fac_q) + rem;
		for (int k = 0; k < MAX_OPS; k++)
		begin
			addrs[k] = base + addr_t'(k) * stride_q;
			// numerator k * (g mod s), unused slots zero
			if (factor_t'(k) < fac_q)
				twdl_numrtr[k] = twdl_t'(k) * twdl_t'(rem);
			else
				twdl_numrtr[k] = '0;
		end
	end

endmodule

`default_nettype wire

/* source/mrd_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_ctrl_fsm import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  nfac_t num_factors,
	input  factor_t [MAX_STAGES-1:0] factors,
	input  logic in_valid,
	input  logic rd_end,
	input  stage_t cnt_stage,
	output fsm_state_t state,
	output logic busy,
	output logic done
);

	fsm_state_t state_nxt;
	nfac_t nfac_q;
	addr_t last_addr;
	addr_t wr_cnt;
	stage_t last_stage;
	logic sink_last;

	// configuration taken with start
	always_ff @(posedge clk)
	begin
		if (state == IDLE && start)
		begin
			nfac_q <= num_factors;
			last_addr <= addr_t'(factor_prod(factors, num_factors) - prod_t'(1));
		end
	end

	// sink write count
	always_ff @(posedge clk)
	begin
		if (!rst_n || state != SINK)
			wr_cnt <= '0;
		else if (in_valid)
			wr_cnt <= wr_cnt + addr_t'(1);
	end

	assign sink_last = (state == SINK) && in_valid && (wr_cnt == last_addr);
	assign last_stage = stage_t'(nfac_q - nfac_t'(1));

	// --------------------
	// next state
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:       if (start) state_nxt = SINK;
			SINK:       if (sink_last) state_nxt = RD;
			RD:         if (rd_end) state_nxt = STAGE_STEP;
			STAGE_STEP: state_nxt = (cnt_stage == last_stage) ? SOURCE : RD;
			SOURCE:     state_nxt = IDLE;
			default:    state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	assign busy = (state != IDLE);
	assign done = (state == SOURCE);

endmodule

`default_nettype wire

/* source/mrd_operand_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mrd_operand_if import mrd_pkg::*; ();

	logic valid;
	stage_t stage;
	factor_t factor;
	// slots at or above factor carry zero
	sample_t [MAX_OPS-1:0] data;
	twdl_t [MAX_OPS-1:0] twdl_numrtr;
	twdl_t twdl_demontr;

	modport source
	(
		output valid,
		output stage,
		output factor,
		output data,
		output twdl_numrtr,
		output twdl_demontr
	);

	modport sink
	(
		input valid,
		input stage,
		input factor,
		input data,
		input twdl_numrtr,
		input twdl_demontr
	);

endinterface

`default_nettype wire

/* source/mrd_pkg.sv */
`default_nettype none

package mrd_pkg;

	// --------------------
	// sizes
	localparam int NUM_BANKS = 7;
	localparam int BANK_ROWS = 64;
	localparam int MAX_OPS = 5;
	localparam int MAX_STAGES = 4;
	localparam int RD_LATENCY = 4;

	// --------------------
	// widths
	typedef logic signed [15:0] sample_t;
	typedef logic [8:0] addr_t;
	typedef logic [5:0] row_t;
	typedef logic [2:0] bank_t;
	typedef logic [2:0] factor_t;
	typedef logic [1:0] stage_t;
	typedef logic [8:0] twdl_t;
	typedef logic [2:0] nfac_t;
	typedef logic [9:0] prod_t;

	// marks an operand slot that reads no bank
	localparam bank_t BANK_INVALID = 3'd7;

	typedef enum logic [2:0]
	{
		IDLE,
		SINK,
		RD,
		STAGE_STEP,
		SOURCE
	} fsm_state_t;

	// product of the first cnt factors, 1 for an empty set
	function automatic prod_t factor_prod(input factor_t [MAX_STAGES-1:0] f, input nfac_t cnt);
		prod_t p;
		p = prod_t'(1);
		for (int i = 0; i < MAX_STAGES; i++)
		begin
			if (i < int'(cnt))
				p = p * prod_t'(f[i]);
		end
		return p;
	endfunction

endpackage

`default_nettype wire

/* source/mrd_read_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_read_seq import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  fsm_state_t state,
	input  nfac_t num_factors,
	input  factor_t [MAX_STAGES-1:0] factors,
	mrd_bank_if.request bank,
	mrd_operand_if.source op,
	output logic rd_end,
	output stage_t cnt_stage
);

	factor_t [MAX_STAGES-1:0] factors_q;
	nfac_t nfac_q;
	prod_t n_pts;
	fsm_state_t state_q;
	logic rd_entry;
	factor_t fac_q;
	addr_t stride_q;
	addr_t grp_last;
	addr_t grp_cnt;
	logic active;
	logic [RD_LATENCY-1:0] en_pipe;
	logic addr_valid;
	addr_t [MAX_OPS-1:0] addrs;
	twdl_t [MAX_OPS-1:0] twdl_numrtr;
	twdl_t [MAX_OPS-1:0] tw_d1;
	twdl_t [MAX_OPS-1:0] tw_d2;
	bank_t [MAX_OPS-1:0] bank_index;
	sample_t [MAX_OPS-1:0] slot_data;

	// config frozen once the run leaves IDLE
	always_ff @(posedge clk)
	begin
		if (state == IDLE)
		begin
			factors_q <= factors;
			nfac_q <= num_factors;
		end
	end

	assign n_pts = factor_prod(factors_q, nfac_q);
	assign rd_entry = (state == RD) && (state_q != RD);

	// --------------------
	// stage setup on RD entry
	always_ff @(posedge clk)
	begin
		if (rd_entry)
		begin
			fac_q <= factors_q[cnt_stage];
			// N over the factors up to this stage
			stride_q <= addr_t'(n_pts / factor_prod(factors_q, {1'b0, cnt_stage} + nfac_t'(1)));
			grp_last <= addr_t'(n_pts / prod_t'(factors_q[cnt_stage]) - prod_t'(1));
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= IDLE;
			active <= 1'b0;
			grp_cnt <= '0;
			cnt_stage <= '0;
			en_pipe <= '0;
		end
		else
		begin
			state_q <= state;
			if (rd_entry)
			begin
				active <= 1'b1;
				grp_cnt <= '0;
			end
			else if (active)
			begin
				grp_cnt <= grp_cnt + addr_t'(1);
				if (grp_cnt == grp_last)
					active <= 1'b0;
			end
			if (state == SOURCE)
				cnt_stage <= '0;
			else if (state == STAGE_STEP)
				cnt_stage <= cnt_stage + stage_t'(1);
			// one bit per pipeline step
			en_pipe <= {en_pipe[RD_LATENCY-2:0], active};
		end
	end

	assign op.valid = en_pipe[RD_LATENCY-1];
	// last group of the stage at the output
	assign rd_end = en_pipe[RD_LATENCY-1] & ~en_pipe[RD_LATENCY-2];

	mrd_cta_addr u_cta_addr (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue       (active),
		.group       (grp_cnt),
		.stride      (stride_q),
		.factor      (fac_q),
		.addrs       (addrs),
		.twdl_numrtr (twdl_numrtr),
		.valid       (addr_valid)
	);

	mrd_bank_map u_bank_map (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid      (addr_valid),
		.addrs      (addrs),
		.factor     (fac_q),
		.bank       (bank),
		.bank_index (bank_index)
	);

	// --------------------
	// operand assembly
	always_comb
	begin
		for (int k = 0; k < MAX_OPS; k++)
		begin
			slot_data[k] = '0;
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				if (bank_index[k] == bank_t'(b))
					slot_data[k] = bank.rdata[b];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		tw_d1 <= twdl_numrtr;
		tw_d2 <= tw_d1;
		op.data <= slot_data;
		op.twdl_numrtr <= tw_d2;
		op.factor <= fac_q;
		op.stage <= cnt_stage;
		op.twdl_demontr <= twdl_t'(stride_q * addr_t'(fac_q));
	end

endmodule

`default_nettype wire

/* source/mrd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_top import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  nfac_t num_factors,
	input  factor_t [MAX_STAGES-1:0] factors,
	input  logic in_valid,
	input  sample_t in_data,
	output logic busy,
	output logic out_valid,
	output stage_t out_stage,
	output factor_t out_factor,
	output sample_t [MAX_OPS-1:0] out_data,
	output twdl_t [MAX_OPS-1:0] out_twdl_numrtr,
	output twdl_t out_twdl_demontr,
	output logic done
);

	fsm_state_t state;
	logic rd_end;
	stage_t cnt_stage;

	mrd_bank_if bank_bus ();
	mrd_operand_if op_bus ();

	mrd_ctrl_fsm u_ctrl_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.num_factors (num_factors),
		.factors     (factors),
		.in_valid    (in_valid),
		.rd_end      (rd_end),
		.cnt_stage   (cnt_stage),
		.state       (state),
		.busy        (busy),
		.done        (done)
	);

	mrd_read_seq u_read_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (state),
		.num_factors (num_factors),
		.factors     (factors),
		.bank        (bank_bus.request),
		.op          (op_bus.source),
		.rd_end      (rd_end),
		.cnt_stage   (cnt_stage)
	);

	mrd_bank_mem u_bank_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.in_valid (in_valid),
		.in_data  (in_data),
		.bank     (bank_bus.memory)
	);

	// operand group straight to the pins
	assign out_valid = op_bus.valid;
	assign out_stage = op_bus.stage;
	assign out_factor = op_bus.factor;
	assign out_data = op_bus.data;
	assign out_twdl_numrtr = op_bus.twdl_numrtr;
	assign out_twdl_demontr = op_bus.twdl_demontr;

endmodule

`default_nettype wire

/* test/mrd_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_properties import mrd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  fsm_state_t state,
	input  logic [RD_LATENCY-1:0] en_pipe,
	input  bank_t [MAX_OPS-1:0] bank_index,
	input  logic rd_end
);

	logic banks_distinct;
	int fail_cnt = 0;

	// used slots of one group must read different banks
	always_comb
	begin
		banks_distinct = 1'b1;
		for (int i = 0; i < MAX_OPS; i++)
		begin
			for (int j = i + 1; j < MAX_OPS; j++)
			begin
				if (bank_index[i] != BANK_INVALID && bank_index[i] == bank_index[j])
					banks_distinct = 1'b0;
			end
		end
	end

	// --------------------
	// bank_index lines up with the third pipeline step
	assert property (@(posedge clk) disable iff (!rst_n)
		en_pipe[RD_LATENCY-2] |-> banks_distinct)
		else
		begin
			fail_cnt++;
			$error("two operand slots of one group share a bank");
		end

	// output valid only while the stage is being read
	assert property (@(posedge clk) disable iff (!rst_n)
		en_pipe[RD_LATENCY-1] |-> (state == RD))
		else
		begin
			fail_cnt++;
			$error("out_valid high outside RD");
		end

	// a single rd_end pulse gives a single STAGE_STEP cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		rd_end |=> (state == STAGE_STEP))
		else
		begin
			fail_cnt++;
			$error("rd_end did not move the FSM to STAGE_STEP for exactly one cycle");
		end

endmodule

bind mrd_read_seq mrd_properties u_properties
(
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.en_pipe    (en_pipe),
	.bank_index (bank_index),
	.rd_end     (rd_end)
);

`default_nettype wire

/* test/mrd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mrd_tb import mrd_pkg::*;
();

	localparam int NUM_RUNS = 10;
	localparam int MAX_N = 448;
	localparam int CLK_HALF = 4;
	// sink with gaps plus every stage's groups and pipeline tail
	localparam int RUN_CYCLES = 2 * MAX_N + MAX_STAGES * (MAX_N / 2 + RD_LATENCY + 4) + 40;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_CYCLES + 200;

	typedef struct packed
	{
		stage_t stage;
		factor_t factor;
		addr_t grp;
		sample_t [MAX_OPS-1:0] data;
		twdl_t [MAX_OPS-1:0] numrtr;
		twdl_t demontr;
	} group_t;

	logic clk;
	logic rst_n;
	logic start;
	nfac_t num_factors;
	factor_t [MAX_STAGES-1:0] factors;
	logic in_valid;
	sample_t in_data;
	logic busy;
	logic out_valid;
	stage_t out_stage;
	factor_t out_factor;
	sample_t [MAX_OPS-1:0] out_data;
	twdl_t [MAX_OPS-1:0] out_twdl_numrtr;
	twdl_t out_twdl_demontr;
	logic done;

	integer seed;
	int errors;
	int checks;
	int assert_fails;
	int run_idx;
	group_t exp_q[$];
	sample_t smp [MAX_N];

	mrd_top uut (
		.clk               (clk),
		.rst_n             (rst_n),
		.start             (start),
		.num_factors       (num_factors),
		.factors           (factors),
		.in_valid          (in_valid),
		.in_data           (in_data),
		.busy              (busy),
		.out_valid         (out_valid),
		.out_stage         (out_stage),
		.out_factor        (out_factor),
		.out_data          (out_data),
		.out_twdl_numrtr   (out_twdl_numrtr),
		.out_twdl_demontr  (out_twdl_demontr),
		.done              (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the runs did not finish", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// --------------------
	// compare tasks
	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("error %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_twdl(input string name, input twdl_t exp, input twdl_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("error %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_factor(input string name, input factor_t exp, input factor_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("error %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_stage(input string name, input stage_t exp, input stage_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("error %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic compare_group(input group_t e);
		string name;
		name = $sformatf("run%0d stage%0d group%0d", run_idx, e.stage, e.grp);
		check_stage({name, " stage"}, e.stage, out_stage);
		check_factor({name, " factor"}, e.factor, out_factor);
		for (int k = 0; k < MAX_OPS; k++)
		begin
			check_sample($sformatf("%s data[%0d]", name, k), e.data[k], out_data[k]);
			check_twdl($sformatf("%s numerator[%0d]", name, k), e.numrtr[k], out_twdl_numrtr[k]);
		end
		check_twdl({name, " denominator"}, e.demontr, out_twdl_demontr);
	endtask

	// output side sampled mid-cycle
	always @(negedge clk)
	begin
		if (rst_n && out_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("out_valid high in run %0d with no group left to expect", run_idx);
			end
			else
				compare_group(exp_q.pop_front());
		end
	end

	// --------------------
	// model
	// operand k of group g at (g / s) * s * f + (g % s) + k * s
	task automatic build_expected(input nfac_t nf, input factor_t [MAX_STAGES-1:0] fs,
		input int n);
		int prod;
		int stride;
		int fac;
		int q;
		int r;
		group_t e;
		prod = 1;
		for (int s = 0; s < int'(nf); s++)
		begin
			fac = int'(fs[s]);
			prod = prod * fac;
			stride = n / prod;
			for (int g = 0; g < n / fac; g++)
			begin
				q = g / stride;
				r = g % stride;
				e.stage = stage_t'(s);
				e.factor = factor_t'(fac);
				e.grp = addr_t'(g);
				e.demontr = twdl_t'(stride * fac);
				for (int k = 0; k < MAX_OPS; k++)
				begin
					if (k < fac)
					begin
						e.data[k] = smp[q * stride * fac + r + k * stride];
						e.numrtr[k] = twdl_t'(k * r);
					end
					else
					begin
						e.data[k] = '0;
						e.numrtr[k] = '0;
					end
				end
				exp_q.push_back(e);
			end
		end
	endtask

	// radices 2 to 5 redrawn until N fits the banks
	task automatic pick_factors(input int want, output nfac_t nf,
		output factor_t [MAX_STAGES-1:0] fs, output int n);
		int p;
		p = MAX_N + 1;
		while (p > MAX_N)
		begin
			p = 1;
			for (int s = 0; s < MAX_STAGES; s++)
			begin
				if (s < want)
				begin
					fs[s] = factor_t'(2 + rand_below(4));
					p = p * int'(fs[s]);
				end
				else
					fs[s] = factor_t'(rand_below(8));
			end
		end
		nf = nfac_t'(want);
		n = p;
	endtask

	task automatic idle_check(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			tick();
			in_valid = (rand_below(3) == 0);
			in_data = sample_t'($random(seed));
			@(negedge clk);
			if (busy !== 1'b0 || out_valid !== 1'b0 || done !== 1'b0)
			begin
				errors++;
				$display("busy, out_valid or done is high while idle without start");
			end
		end
		tick();
		in_valid = 1'b0;
	endtask

	// --------------------
	// one full run
	task automatic do_run(input int want);
		nfac_t nf;
		factor_t [MAX_STAGES-1:0] fs;
		int n;
		int wait_cnt;
		pick_factors(want, nf, fs, n);
		for (int i = 0; i < n; i++)
			smp[i] = sample_t'($random(seed));
		build_expected(nf, fs, n);
		tick();
		num_factors = nf;
		factors = fs;
		start = 1'b1;
		tick();
		start = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			// gaps with start pulses that SINK must ignore
			while (rand_below(4) == 0)
			begin
				in_valid = 1'b0;
				start = (rand_below(2) == 0);
				tick();
			end
			start = 1'b0;
			in_valid = 1'b1;
			in_data = smp[i];
			tick();
		end
		// stray start and write during RD
		start = 1'b1;
		in_valid = 1'b1;
		in_data = sample_t'($random(seed));
		tick();
		tick();
		start = 1'b0;
		in_valid = 1'b0;
		if (busy !== 1'b1)
		begin
			errors++;
			$display("busy is low in run %0d while the stages are read", run_idx);
		end
		wait_cnt = 0;
		while (done !== 1'b1 && wait_cnt < RUN_CYCLES)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (done !== 1'b1)
		begin
			errors++;
			$display("done did not arrive in run %0d", run_idx);
		end
		else
		begin
			@(negedge clk);
			if (done !== 1'b0 || busy !== 1'b0)
			begin
				errors++;
				$display("done or busy still high one cycle after done in run %0d", run_idx);
			end
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("run %0d ended with %0d groups never seen", run_idx, exp_q.size());
			exp_q.delete();
		end
	endtask

	initial
	begin
		seed = 8;
		errors = 0;
		checks = 0;
		assert_fails = 0;
		run_idx = 0;
		rst_n = 1'b0;
		start = 1'b0;
		num_factors = nfac_t'(1);
		factors = '0;
		in_valid = 1'b0;
		in_data = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_check(20);
		// single and four stage sets alternate before random depths
		for (int r = 0; r < NUM_RUNS; r++)
		begin
			run_idx = r;
			if (r < 4)
				do_run((r % 2 == 0) ? 1 : 4);
			else
				do_run(1 + rand_below(MAX_STAGES));
		end
		assert_fails = uut.u_read_seq.u_properties.fail_cnt;
		$display("checks %0d errors %0d assertion failures %0d", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
